//--- Bender.yml
package:
  name: rv32i_core

sources:
  - src/rv_pkg.sv
  - src/regfile.sv
  - src/alu.sv
  - src/decode.sv
  - src/execute.sv
  - src/result.sv
  - src/core_top.sv
  - target: test
    files:
      - bench/core_asserts.sv
      - bench/core_tb.sv

//--- bench/core_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module core_asserts
  ( input wire                   clk
  , input wire                   reset
  , input wire                   instr_valid
  , input wire                   redirect
  , input wire rv_pkg::addr_t    redirect_target
  , input wire                   wb_valid
  , input wire rv_pkg::reg_idx_t wb_rd
  );

  int failures = 0;

  // Redirect leaves execute two cycles after acceptance
  redirect_after_accept: assert property (@(posedge clk) disable iff (reset)
    redirect |-> $past(instr_valid, 2))
    else begin
      failures++;
      $error("redirect without an accepted instruction two cycles earlier");
    end

  // Writeback three cycles after acceptance, never to x0
  wb_after_accept: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> $past(instr_valid, 3) && wb_rd != '0)
    else begin
      failures++;
      $error("writeback without matching instruction or with rd zero");
    end

  target_aligned: assert property (@(posedge clk) disable iff (reset)
    redirect |-> !redirect_target[0])
    else begin
      failures++;
      $error("redirect target has bit 0 set");
    end

  // Outputs set under reset must be quiet
  quiet_after_reset: assert property (@(posedge clk)
    $past(reset) |-> !wb_valid && !redirect)
    else begin
      failures++;
      $error("pulse during or right after reset");
    end

endmodule

bind core_top core_asserts u_asserts
  ( .clk, .reset, .instr_valid, .redirect, .redirect_target, .wb_valid, .wb_rd );

`default_nettype wire

//--- bench/core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module core_tb;

  import rv_pkg::*;

  logic     clk;
  logic     reset;
  instr_t   instr;
  addr_t    instr_pc;
  logic     instr_valid;
  logic     redirect;
  addr_t    redirect_target;
  logic     wb_valid;
  reg_idx_t wb_rd;
  data_t    wb_data;

  // Reference model in program order
  data_t    regs [32];
  int       ready [32];
  addr_t    pc;
  int       cyc = 0;
  int       wb_errors = 0;
  int       redirect_errors = 0;
  int       timeout_errors = 0;

  // Expected events tagged with the edge they are due
  int       wb_due [$];
  reg_idx_t wb_rd_q [$];
  data_t    wb_data_q [$];
  int       rdr_due [$];
  addr_t    rdr_target_q [$];

  core_top UUT
    ( .clk, .reset, .instr, .instr_pc, .instr_valid
    , .redirect, .redirect_target, .wb_valid, .wb_rd, .wb_data
    );

  always #10 clk = ~clk;

  // ISA result for OP and OP-IMM
  function automatic data_t arith(input funct3_t f3, input logic alt,
                                  input data_t a, input data_t b);
    data_t r;
    case (f3)
      3'b000:  r = alt ? a - b : a + b;
      3'b001:  r = a << b[4:0];
      3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  r = (a < b) ? 32'd1 : 32'd0;
      3'b100:  r = a ^ b;
      3'b101: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else     r = a >> b[4:0];
      end
      3'b110:  r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // Issue one instruction once its sources are old enough
  task automatic send(input instr_t w, input reg_idx_t s1, input reg_idx_t s2,
                      input logic writes, input reg_idx_t rd, input data_t value,
                      input logic control, input logic taken, input addr_t target);
    int need;
    int n;
    need = (ready[s1] > ready[s2]) ? ready[s1] : ready[s2];
    n = 0;
    @(negedge clk);
    while (cyc < need && n < 8) begin
      instr_valid = 1'b0;
      n++;
      @(negedge clk);
    end
    if (cyc < need) begin
      timeout_errors++;
      $display("Gave up waiting for a source register at cycle %0d", cyc);
    end
    instr       = w;
    instr_pc    = pc;
    instr_valid = 1'b1;
    if (writes && rd != '0) begin
      regs[rd]  = value;
      ready[rd] = cyc + 3;
      wb_due.push_back(cyc + 3);
      wb_rd_q.push_back(rd);
      wb_data_q.push_back(value);
    end
    if (control && taken) begin
      rdr_due.push_back(cyc + 2);
      rdr_target_q.push_back(target);
    end
    pc = (control && taken) ? target : pc + 32'd4;
    // Fetch leaves two bubbles behind a control transfer
    if (control) begin
      repeat (2) begin
        @(negedge clk);
        instr_valid = 1'b0;
      end
    end
  endtask

  task automatic op_rr(input funct3_t f3, input logic alt, input reg_idx_t rd,
                       input reg_idx_t s1, input reg_idx_t s2);
    send({1'b0, alt, 5'b00000, s2, s1, f3, rd, OPC_OP}, s1, s2, 1'b1, rd,
         arith(f3, alt, regs[s1], regs[s2]), 1'b0, 1'b0, '0);
  endtask

  task automatic op_imm(input funct3_t f3, input reg_idx_t rd, input reg_idx_t s1,
                        input logic [11:0] imm);
    send({imm, s1, f3, rd, OPC_OP_IMM}, s1, 5'd0, 1'b1, rd,
         arith(f3, f3 == 3'b101 && imm[10], regs[s1], {{20{imm[11]}}, imm}),
         1'b0, 1'b0, '0);
  endtask

  // LUI or AUIPC when pc_rel is set
  task automatic upper(input logic pc_rel, input reg_idx_t rd, input logic [19:0] imm);
    send({imm, rd, pc_rel ? OPC_AUIPC : OPC_LUI}, 5'd0, 5'd0, 1'b1, rd,
         (pc_rel ? pc : 32'd0) + {imm, 12'b0}, 1'b0, 1'b0, '0);
  endtask

  task automatic branch(input funct3_t f3, input reg_idx_t s1, input reg_idx_t s2,
                        input logic [12:0] off);
    data_t a;
    data_t b;
    logic  taken;
    a = regs[s1];
    b = regs[s2];
    case (f3)
      F3_BEQ:  taken = a == b;
      F3_BNE:  taken = a != b;
      F3_BLT:  taken = $signed(a) < $signed(b);
      F3_BGE:  taken = $signed(a) >= $signed(b);
      F3_BLTU: taken = a < b;
      default: taken = a >= b;
    endcase
    send({off[12], off[10:5], s2, s1, f3, off[4:1], off[11], OPC_BRANCH}, s1, s2,
         1'b0, 5'd0, '0, 1'b1, taken, pc + {{19{off[12]}}, off});
  endtask

  task automatic jal(input reg_idx_t rd, input logic [20:0] off);
    send({off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL}, 5'd0, 5'd0,
         1'b1, rd, pc + 32'd4, 1'b1, 1'b1, pc + {{11{off[20]}}, off});
  endtask

  task automatic jalr(input reg_idx_t rd, input reg_idx_t s1, input logic [11:0] imm);
    addr_t t;
    t    = regs[s1] + {{20{imm[11]}}, imm};
    t[0] = 1'b0;
    send({imm, s1, 3'b000, rd, OPC_JALR}, s1, 5'd0, 1'b1, rd, pc + 32'd4,
         1'b1, 1'b1, t);
  endtask

  task automatic apply_reset();
    reset       = 1'b1;
    instr_valid = 1'b0;
    // Whatever is in flight is lost
    wb_due.delete();
    wb_rd_q.delete();
    wb_data_q.delete();
    rdr_due.delete();
    rdr_target_q.delete();
    repeat (4) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < 32; i++) begin
      regs[i]  = '0;
      ready[i] = 0;
    end
  endtask

  // Stop issuing and wait for every expected event
  task automatic drain();
    int n;
    n = 0;
    @(negedge clk);
    instr_valid = 1'b0;
    while ((wb_due.size() != 0 || rdr_due.size() != 0) && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (wb_due.size() != 0 || rdr_due.size() != 0) begin
      timeout_errors++;
      $display("Timeout: pipeline did not drain, %0d writes and %0d redirects left",
               wb_due.size(), rdr_due.size());
      wb_due.delete();
      wb_rd_q.delete();
      wb_data_q.delete();
      rdr_due.delete();
      rdr_target_q.delete();
    end
  endtask

  // Compare outputs with the model at every rising edge
  always @(posedge clk) begin
    if (!reset) begin
      if (wb_due.size() != 0 && wb_due[0] == cyc) begin
        assert (wb_valid) else begin
          wb_errors++;
          $display("Missing writeback of x%0d at cycle %0d", wb_rd_q[0], cyc);
        end
        if (wb_valid) begin
          assert (wb_rd == wb_rd_q[0]) else begin
            wb_errors++;
            $display("FAIL wb_rd expected %h got %h", wb_rd_q[0], wb_rd);
          end
          assert (wb_data == wb_data_q[0]) else begin
            wb_errors++;
            $display("FAIL wb_data expected %h got %h", wb_data_q[0], wb_data);
          end
        end
        void'(wb_due.pop_front());
        void'(wb_rd_q.pop_front());
        void'(wb_data_q.pop_front());
      end else begin
        assert (!wb_valid) else begin
          wb_errors++;
          $display("Unexpected writeback to x%0d at cycle %0d", wb_rd, cyc);
        end
      end
      if (rdr_due.size() != 0 && rdr_due[0] == cyc) begin
        assert (redirect) else begin
          redirect_errors++;
          $display("Missing redirect at cycle %0d", cyc);
        end
        if (redirect) begin
          assert (redirect_target == rdr_target_q[0]) else begin
            redirect_errors++;
            $display("FAIL redirect_target expected %h got %h",
                     rdr_target_q[0], redirect_target);
          end
        end
        void'(rdr_due.pop_front());
        void'(rdr_target_q.pop_front());
      end else begin
        assert (!redirect) else begin
          redirect_errors++;
          $display("Unexpected redirect at cycle %0d", cyc);
        end
      end
    end
    cyc <= cyc + 1;
  end

  initial begin
    funct3_t       conds [6];
    logic [31:0]   bits;
    funct3_t       f3;
    logic          alt;
    logic [11:0]   imm;
    int            total;
    clk         = 1'b0;
    reset       = 1'b1;
    instr       = '0;
    instr_pc    = '0;
    instr_valid = 1'b0;
    pc          = 32'h100;
    void'($urandom(32'hb5ee));
    apply_reset();

    // Operands around the sign bit
    upper(1'b0, 5'd1, 20'h80000);
    op_imm(3'b000, 5'd2, 5'd0, 12'hfff);
    op_imm(3'b000, 5'd3, 5'd0, 12'h005);
    upper(1'b0, 5'd4, 20'h12345);
    op_imm(3'b000, 5'd4, 5'd4, 12'h678);
    upper(1'b1, 5'd5, 20'h00001);

    op_rr(3'b000, 1'b0, 5'd6, 5'd3, 5'd4);
    op_rr(3'b000, 1'b1, 5'd7, 5'd3, 5'd4);
    op_rr(3'b111, 1'b0, 5'd8, 5'd2, 5'd4);
    op_rr(3'b110, 1'b0, 5'd9, 5'd1, 5'd3);
    op_rr(3'b100, 1'b0, 5'd10, 5'd2, 5'd4);
    op_rr(3'b010, 1'b0, 5'd11, 5'd1, 5'd3);
    op_rr(3'b011, 1'b0, 5'd12, 5'd1, 5'd3);
    op_rr(3'b001, 1'b0, 5'd13, 5'd4, 5'd3);
    op_rr(3'b101, 1'b0, 5'd14, 5'd1, 5'd3);
    op_rr(3'b101, 1'b1, 5'd15, 5'd1, 5'd3);
    // Shift amount 35 uses only its low five bits
    op_imm(3'b000, 5'd16, 5'd0, 12'h023);
    op_rr(3'b001, 1'b0, 5'd17, 5'd4, 5'd16);

    op_imm(3'b010, 5'd18, 5'd1, 12'h001);
    op_imm(3'b011, 5'd19, 5'd3, 12'hfff);
    op_imm(3'b100, 5'd20, 5'd4, 12'hfff);
    op_imm(3'b111, 5'd21, 5'd2, 12'h0f0);
    op_imm(3'b110, 5'd21, 5'd21, 12'h80f);
    op_imm(3'b001, 5'd22, 5'd3, 12'h004);
    op_imm(3'b101, 5'd23, 5'd1, 12'h01f);
    op_imm(3'b101, 5'd24, 5'd1, 12'h404);

    // Writes to x0 are dropped
    op_rr(3'b000, 1'b0, 5'd0, 5'd3, 5'd3);
    op_rr(3'b000, 1'b0, 5'd25, 5'd0, 5'd3);

    conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    foreach (conds[i]) begin
      branch(conds[i], 5'd1, 5'd3, 13'h0010);
      branch(conds[i], 5'd3, 5'd1, 13'h1ff4);
      branch(conds[i], 5'd3, 5'd3, 13'h0008);
    end

    jal(5'd26, 21'h000040);
    jal(5'd0, 21'h1fffe0);
    jalr(5'd27, 5'd4, 12'h003);
    jalr(5'd28, 5'd3, 12'hfff);

    for (int k = 0; k < 60; k++) begin
      bits = $urandom;
      f3   = bits[2:0];
      alt  = bits[18] && (f3 == 3'b000 || f3 == 3'b101);
      imm  = bits[31:20];
      if (bits[19]) begin
        op_rr(f3, alt, bits[7:3], bits[12:8], bits[17:13]);
      end else begin
        if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, alt, 5'b00000, imm[4:0]};
        op_imm(f3, bits[7:3], bits[12:8], imm);
      end
    end

    // Second reset hits a jump and earlier writes still in flight
    @(negedge clk);
    instr       = {1'b0, 10'h020, 1'b0, 8'h00, 5'd26, OPC_JAL};
    instr_pc    = pc;
    instr_valid = 1'b1;
    @(negedge clk);
    apply_reset();

    // Register file reads zero again
    op_rr(3'b000, 1'b0, 5'd29, 5'd1, 5'd2);
    op_rr(3'b110, 1'b0, 5'd30, 5'd4, 5'd3);
    drain();

    total = wb_errors + redirect_errors + timeout_errors + UUT.u_asserts.failures;
    $display("Errors: writeback %0d, redirect %0d, timeout %0d, assertion %0d",
             wb_errors, redirect_errors, timeout_errors, UUT.u_asserts.failures);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
src/rv_pkg.sv
src/regfile.sv
src/alu.sv
src/decode.sv
src/execute.sv
src/result.sv
src/core_top.sv
bench/core_asserts.sv
bench/core_tb.sv

//--- src/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu
  ( input  wire rv_pkg::data_t   a
  , input  wire rv_pkg::data_t   b
  , input  wire rv_pkg::alu_op_t alu_op
  , output rv_pkg::data_t        out
  , output logic                 zero
  );

  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Shifts only look at the low five bits
  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (alu_op)
      ALU_ADD:  out = a + b;
      ALU_SUB:  out = a - b;
      ALU_AND:  out = a & b;
      ALU_OR:   out = a | b;
      ALU_XOR:  out = a ^ b;
      ALU_SLT:  out = {31'b0, lt_signed};
      ALU_SLTU: out = {31'b0, lt_unsigned};
      ALU_SLL:  out = a << shamt;
      ALU_SRL:  out = a >> shamt;
      ALU_SRA:  out = $signed(a) >>> shamt;
      default:  out = '0;
    endcase
  end

  assign zero = (out == '0);

endmodule

`default_nettype wire

//--- src/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top
  ( input  wire                 clk
  , input  wire                 reset
  , input  wire rv_pkg::instr_t  instr
  , input  wire rv_pkg::addr_t   instr_pc
  , input  wire                 instr_valid
  , output logic                 redirect
  , output rv_pkg::addr_t        redirect_target
  , output logic                 wb_valid
  , output rv_pkg::reg_idx_t     wb_rd
  , output rv_pkg::data_t        wb_data
  );

  import rv_pkg::*;

  // Register file ports
  reg_idx_t rs1, rs2, rf_waddr;
  data_t    rs1_data, rs2_data, rf_wdata;
  logic     rf_we;

  // Decode to execute
  logic        d_valid, d_reg_write;
  data_t       d_rd1, d_rd2, d_imm;
  addr_t       d_pc;
  reg_idx_t    d_rd;
  alu_op_t     d_alu_op;
  alu_src_a_t  d_alu_src_a;
  alu_src_b_t  d_alu_src_b;
  result_src_t d_result_src;
  pc_src_t     d_pc_src;
  funct3_t     d_funct3;

  // Execute to result
  logic        e_reg_write;
  reg_idx_t    e_rd;
  data_t       e_alu_result;
  addr_t       e_link;
  result_src_t e_result_src;

  decode u_decode
    ( .clk, .reset, .instr, .instr_pc, .instr_valid
    , .rs1, .rs2, .rs1_data, .rs2_data
    , .d_valid, .d_rd1, .d_rd2, .d_imm, .d_pc, .d_rd
    , .d_alu_op, .d_alu_src_a, .d_alu_src_b, .d_result_src
    , .d_pc_src, .d_funct3, .d_reg_write
    );

  execute u_execute
    ( .clk, .reset
    , .d_valid, .d_rd1, .d_rd2, .d_imm, .d_pc, .d_rd
    , .d_alu_op, .d_alu_src_a, .d_alu_src_b, .d_result_src
    , .d_pc_src, .d_funct3, .d_reg_write
    , .e_reg_write, .e_rd, .e_alu_result, .e_link, .e_result_src
    , .redirect, .redirect_target
    );

  result u_result
    ( .clk, .reset
    , .e_reg_write, .e_rd, .e_alu_result, .e_link, .e_result_src
    , .rf_we, .rf_waddr, .rf_wdata
    , .wb_valid, .wb_rd, .wb_data
    );

  regfile u_regfile
    ( .clk, .reset, .rs1, .rs2, .rs1_data, .rs2_data
    , .we ( rf_we ), .waddr ( rf_waddr ), .wdata ( rf_wdata )
    );

endmodule

`default_nettype wire

//--- src/decode.sv
`timescale 1ns/10ps
`default_nettype none

module decode
  ( input  wire                     clk
  , input  wire                     reset
  , input  wire rv_pkg::instr_t      instr
  , input  wire rv_pkg::addr_t       instr_pc
  , input  wire                     instr_valid
  , output rv_pkg::reg_idx_t         rs1
  , output rv_pkg::reg_idx_t         rs2
  , input  wire rv_pkg::data_t       rs1_data
  , input  wire rv_pkg::data_t       rs2_data
  , output logic                     d_valid
  , output rv_pkg::data_t            d_rd1
  , output rv_pkg::data_t            d_rd2
  , output rv_pkg::data_t            d_imm
  , output rv_pkg::addr_t            d_pc
  , output rv_pkg::reg_idx_t         d_rd
  , output rv_pkg::alu_op_t          d_alu_op
  , output rv_pkg::alu_src_a_t       d_alu_src_a
  , output rv_pkg::alu_src_b_t       d_alu_src_b
  , output rv_pkg::result_src_t      d_result_src
  , output rv_pkg::pc_src_t          d_pc_src
  , output rv_pkg::funct3_t          d_funct3
  , output logic                     d_reg_write
  );

  import rv_pkg::*;

  logic [6:0]  opcode;
  reg_idx_t    rd;
  funct3_t     funct3;
  logic        funct7_alt;
  data_t       imm_i;
  data_t       imm_b;
  data_t       imm_u;
  data_t       imm_j;
  data_t       imm;
  alu_op_t     alu_op;
  alu_src_a_t  alu_src_a;
  alu_src_b_t  alu_src_b;
  result_src_t result_src;
  pc_src_t     pc_src;
  logic        reg_write;

  // funct3 to ALU op for OP and OP-IMM, alt selects sub / sra
  function automatic alu_op_t arith_op(input funct3_t f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode     = instr[6:0];
  assign rd         = instr[11:7];
  assign funct3     = instr[14:12];
  assign rs1        = instr[19:15];
  assign rs2        = instr[24:20];
  assign funct7_alt = instr[30];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // Defaults form a bubble for unsupported opcodes
    imm        = imm_i;
    alu_op     = ALU_ADD;
    alu_src_a  = ALU_SRC_A_RD1;
    alu_src_b  = ALU_SRC_B_RD2;
    result_src = RESULT_SRC_ALU;
    pc_src     = PC_SRC_INCREMENT;
    reg_write  = 1'b0;
    case (opcode)
      OPC_OP: begin
        alu_op    = arith_op(funct3, funct7_alt);
        reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        // Only the right shift reads bit 30, addi has no subtract form
        alu_op    = arith_op(funct3, funct7_alt && funct3 == 3'b101);
        alu_src_b = ALU_SRC_B_IMM;
        reg_write = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        imm       = imm_u;
        alu_src_a = (opcode == OPC_LUI) ? ALU_SRC_A_ZERO : ALU_SRC_A_PC;
        alu_src_b = ALU_SRC_B_IMM;
        reg_write = 1'b1;
      end
      OPC_JAL: begin
        imm        = imm_j;
        result_src = RESULT_SRC_LINK;
        pc_src     = PC_SRC_JAL;
        reg_write  = 1'b1;
      end
      OPC_JALR: begin
        alu_src_b  = ALU_SRC_B_IMM;
        result_src = RESULT_SRC_LINK;
        pc_src     = PC_SRC_JALR;
        reg_write  = 1'b1;
      end
      OPC_BRANCH: begin
        imm    = imm_b;
        pc_src = PC_SRC_BRANCH;
        // Equality via zero flag, ordering via slt/sltu
        case (funct3)
          F3_BEQ, F3_BNE: alu_op = ALU_SUB;
          F3_BLT, F3_BGE: alu_op = ALU_SLT;
          default:        alu_op = ALU_SLTU;
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      d_valid     <= 1'b0;
      d_reg_write <= 1'b0;
    end else begin
      d_valid     <= instr_valid;
      d_reg_write <= instr_valid && reg_write && (rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    d_rd1        <= rs1_data;
    d_rd2        <= rs2_data;
    d_imm        <= imm;
    d_pc         <= instr_pc;
    d_rd         <= rd;
    d_alu_op     <= alu_op;
    d_alu_src_a  <= alu_src_a;
    d_alu_src_b  <= alu_src_b;
    d_result_src <= result_src;
    d_pc_src     <= pc_src;
    d_funct3     <= funct3;
  end

endmodule

`default_nettype wire

//--- src/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute
  ( input  wire                      clk
  , input  wire                      reset
  , input  wire                      d_valid
  , input  wire rv_pkg::data_t        d_rd1
  , input  wire rv_pkg::data_t        d_rd2
  , input  wire rv_pkg::data_t        d_imm
  , input  wire rv_pkg::addr_t        d_pc
  , input  wire rv_pkg::reg_idx_t     d_rd
  , input  wire rv_pkg::alu_op_t      d_alu_op
  , input  wire rv_pkg::alu_src_a_t   d_alu_src_a
  , input  wire rv_pkg::alu_src_b_t   d_alu_src_b
  , input  wire rv_pkg::result_src_t  d_result_src
  , input  wire rv_pkg::pc_src_t      d_pc_src
  , input  wire rv_pkg::funct3_t      d_funct3
  , input  wire                      d_reg_write
  , output logic                      e_reg_write
  , output rv_pkg::reg_idx_t          e_rd
  , output rv_pkg::data_t             e_alu_result
  , output rv_pkg::addr_t             e_link
  , output rv_pkg::result_src_t       e_result_src
  , output logic                      redirect
  , output rv_pkg::addr_t             redirect_target
  );

  import rv_pkg::*;

  data_t alu_a;
  data_t alu_b;
  data_t alu_result;
  logic  alu_zero;
  logic  branch_taken;
  logic  take;
  addr_t target;

  always_comb begin
    case (d_alu_src_a)
      ALU_SRC_A_PC:   alu_a = d_pc;
      ALU_SRC_A_ZERO: alu_a = '0;
      default:        alu_a = d_rd1;
    endcase
  end

  assign alu_b = (d_alu_src_b == ALU_SRC_B_IMM) ? d_imm : d_rd2;

  alu u_alu
    ( .a      ( alu_a      )
    , .b      ( alu_b      )
    , .alu_op ( d_alu_op   )
    , .out    ( alu_result )
    , .zero   ( alu_zero   )
    );

  // slt/sltu leave the comparison in bit 0
  always_comb begin
    case (d_funct3)
      F3_BEQ:  branch_taken = alu_zero;
      F3_BNE:  branch_taken = !alu_zero;
      F3_BLT,
      F3_BLTU: branch_taken = alu_result[0];
      F3_BGE,
      F3_BGEU: branch_taken = !alu_result[0];
      default: branch_taken = 1'b0;
    endcase
  end

  assign take = (d_pc_src == PC_SRC_BRANCH) ? branch_taken : (d_pc_src != PC_SRC_INCREMENT);

  // JALR target is rs1 + imm with bit 0 cleared
  assign target = (d_pc_src == PC_SRC_JALR) ? {alu_result[31:1], 1'b0} : d_pc + d_imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      e_reg_write <= 1'b0;
      redirect    <= 1'b0;
    end else begin
      e_reg_write <= d_reg_write;
      redirect    <= d_valid && take;
    end
  end

  always_ff @(posedge clk) begin
    e_rd            <= d_rd;
    e_alu_result    <= alu_result;
    e_link          <= d_pc + 32'd4;
    e_result_src    <= d_result_src;
    redirect_target <= target;
  end

endmodule

`default_nettype wire

//--- src/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile
  ( input  wire                  clk
  , input  wire                  reset
  , input  wire rv_pkg::reg_idx_t rs1
  , input  wire rv_pkg::reg_idx_t rs2
  , output rv_pkg::data_t         rs1_data
  , output rv_pkg::data_t         rs2_data
  , input  wire                  we
  , input  wire rv_pkg::reg_idx_t waddr
  , input  wire rv_pkg::data_t    wdata
  );

  import rv_pkg::*;

  // No storage for x0
  data_t regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-first bypass of a same-cycle write
  assign rs1_data = (rs1 == '0) ? '0 : (we && waddr == rs1) ? wdata : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (we && waddr == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

//--- src/result.sv
`timescale 1ns/10ps
`default_nettype none

module result
  ( input  wire                      clk
  , input  wire                      reset
  , input  wire                      e_reg_write
  , input  wire rv_pkg::reg_idx_t     e_rd
  , input  wire rv_pkg::data_t        e_alu_result
  , input  wire rv_pkg::addr_t        e_link
  , input  wire rv_pkg::result_src_t  e_result_src
  , output logic                      rf_we
  , output rv_pkg::reg_idx_t          rf_waddr
  , output rv_pkg::data_t             rf_wdata
  , output logic                      wb_valid
  , output rv_pkg::reg_idx_t          wb_rd
  , output rv_pkg::data_t             wb_data
  );

  import rv_pkg::*;

  // Jumps write the return address, everything else the ALU value
  assign rf_wdata = (e_result_src == RESULT_SRC_LINK) ? e_link : e_alu_result;
  assign rf_we    = e_reg_write;
  assign rf_waddr = e_rd;

  // Report the same write one cycle later
  always_ff @(posedge clk) begin
    if (reset) wb_valid <= 1'b0;
    else       wb_valid <= rf_we;
  end

  always_ff @(posedge clk) begin
    wb_rd   <= rf_waddr;
    wb_data <= rf_wdata;
  end

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // Datapath widths
  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  funct3_t;

  // ALU operation codes
  typedef logic [3:0] alu_op_t;
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLT  = 4'd5;
  localparam alu_op_t ALU_SLTU = 4'd6;
  localparam alu_op_t ALU_SLL  = 4'd7;
  localparam alu_op_t ALU_SRL  = 4'd8;
  localparam alu_op_t ALU_SRA  = 4'd9;

  // Operand A source, the zero choice serves LUI
  typedef logic [1:0] alu_src_a_t;
  localparam alu_src_a_t ALU_SRC_A_RD1  = 2'd0;
  localparam alu_src_a_t ALU_SRC_A_PC   = 2'd1;
  localparam alu_src_a_t ALU_SRC_A_ZERO = 2'd2;

  // Operand B source
  typedef logic alu_src_b_t;
  localparam alu_src_b_t ALU_SRC_B_RD2 = 1'b0;
  localparam alu_src_b_t ALU_SRC_B_IMM = 1'b1;

  // Value written back to rd
  typedef logic result_src_t;
  localparam result_src_t RESULT_SRC_ALU  = 1'b0;
  localparam result_src_t RESULT_SRC_LINK = 1'b1;

  // Next PC kind
  typedef logic [1:0] pc_src_t;
  localparam pc_src_t PC_SRC_INCREMENT = 2'd0;
  localparam pc_src_t PC_SRC_BRANCH    = 2'd1;
  localparam pc_src_t PC_SRC_JAL       = 2'd2;
  localparam pc_src_t PC_SRC_JALR      = 2'd3;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // Branch conditions in funct3
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

endpackage

`default_nettype wire
